//--- huff_pkg.sv
package huff_pkg;

  // Symbol alphabet
  localparam int SYM_W = 4;
  localparam int NUM_SYM = 16;

  // Tree nodes: leaves 0 to 15, internal nodes 16 to 30
  localparam int NODE_W = 5;
  localparam int NUM_NODES = 31;

  // Occurrence counters saturate at this width
  localparam int CNT_W = 8;

  // Code storage
  localparam int LEN_W = 4;
  localparam int CODE_MAX = 15;

  // Symbols granted to the source but not yet received
  localparam int IN_CREDITS = 2;

  // Bit credits held by translation after reset
  localparam int OUT_CREDITS = 4;

  // Engine phases, one per stage
  typedef enum logic [2:0] {
    IDLE,
    COUNT,
    BUILD,
    CODE,
    ENCODE,
    DONE
  } phase_t;

endpackage

//--- huff_controller.sv
`timescale 1ns/100ps
module huff_controller (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             start_i,
  input  logic             histo_done_i,
  input  logic             tree_done_i,
  input  logic             code_done_i,
  input  logic             enc_done_i,
  output huff_pkg::phase_t phase_o,
  output logic             done_o
);
  import huff_pkg::*;

  phase_t phase_q;
  phase_t phase_d;

  // Each stage hands over on its own done pulse
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      IDLE, DONE: begin
        if (start_i) begin
          phase_d = COUNT;
        end
      end
      COUNT: begin
        if (histo_done_i) begin
          phase_d = BUILD;
        end
      end
      BUILD: begin
        if (tree_done_i) begin
          phase_d = CODE;
        end
      end
      CODE: begin
        if (code_done_i) begin
          phase_d = ENCODE;
        end
      end
      ENCODE: begin
        if (enc_done_i) begin
          phase_d = DONE;
        end
      end
      default: begin
        phase_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      phase_q <= IDLE;
    end else begin
      phase_q <= phase_d;
    end
  end

  assign phase_o = phase_q;
  // High from the cycle after the last bit until a new start
  assign done_o = (phase_q == DONE);

endmodule

//--- huff_histogram.sv
`timescale 1ns/100ps
module huff_histogram (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  huff_pkg::phase_t           phase_i,
  input  logic [huff_pkg::SYM_W-1:0] sym_i,
  input  logic                       sym_valid_i,
  input  logic                       sym_last_i,
  input  logic [huff_pkg::SYM_W-1:0] cnt_addr_i,
  output logic [huff_pkg::CNT_W-1:0] cnt_o,
  output logic                       histo_done_o
);
  import huff_pkg::*;

  logic [CNT_W-1:0] cnt_q [NUM_SYM];
  logic             in_count_q;
  logic             first;
  logic             hit;

  // First COUNT cycle wipes the previous message
  assign first = (phase_i == COUNT) && !in_count_q;
  assign hit   = (phase_i == COUNT) && sym_valid_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_count_q <= 1'b0;
    end else begin
      in_count_q <= (phase_i == COUNT);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_SYM; i++) begin
      if (first) begin
        cnt_q[i] <= '0;
      end
    end
    if (hit) begin
      if (first) begin
        cnt_q[sym_i] <= CNT_W'(1);
      end else if (cnt_q[sym_i] != '1) begin
        cnt_q[sym_i] <= cnt_q[sym_i] + CNT_W'(1);
      end
    end
  end

  // Counts are read by the tree builder during BUILD
  assign cnt_o = cnt_q[cnt_addr_i];

  // Last symbol is counted on the same edge that leaves COUNT
  assign histo_done_o = hit && sym_last_i;

endmodule

//--- huff_tree_builder.sv
`timescale 1ns/100ps
module huff_tree_builder (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  huff_pkg::phase_t            phase_i,
  input  logic [huff_pkg::CNT_W-1:0]  cnt_i,
  input  logic [huff_pkg::NODE_W-1:0] par_addr_i,
  output logic [huff_pkg::SYM_W-1:0]  cnt_addr_o,
  output logic [huff_pkg::NODE_W-1:0] par_o,
  output logic                        branch_o,
  output logic                        tree_done_o
);
  import huff_pkg::*;

  // Wide enough for the sum of all 16 saturated counts
  typedef logic [CNT_W+SYM_W-1:0] weight_t;

  typedef enum logic [2:0] {S_IDLE, S_LOAD, S_SCAN, S_MERGE, S_FIN} state_t;

  state_t            state_q;
  logic [NODE_W-1:0] idx_q;
  logic [NODE_W-1:0] next_q;
  logic              v1_q;
  logic              v2_q;
  logic [NODE_W-1:0] min1_q;
  logic [NODE_W-1:0] min2_q;
  weight_t           w1_q;
  weight_t           w2_q;

  weight_t           weight [NUM_NODES];
  logic              live   [NUM_NODES];
  logic [NODE_W-1:0] par    [NUM_NODES];
  logic              branch [NUM_NODES];

  weight_t w_cur;
  logic    take1;
  logic    take2;

  // Strict compares keep ties on the lower index
  assign w_cur = weight[idx_q];
  assign take1 = live[idx_q] && (!v1_q || (w_cur < w1_q));
  assign take2 = live[idx_q] && !take1 && (!v2_q || (w_cur < w2_q));

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      idx_q   <= '0;
      next_q  <= '0;
      v1_q    <= 1'b0;
      v2_q    <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (phase_i == BUILD) begin
            state_q <= S_LOAD;
            idx_q   <= '0;
          end
        end
        S_LOAD: begin
          idx_q <= idx_q + 1'b1;
          if (idx_q == NODE_W'(NUM_SYM - 1)) begin
            state_q <= S_SCAN;
            idx_q   <= '0;
            next_q  <= NODE_W'(NUM_SYM);
            v1_q    <= 1'b0;
            v2_q    <= 1'b0;
          end
        end
        S_SCAN: begin
          if (take1) begin
            v1_q <= 1'b1;
            v2_q <= v1_q;
          end else if (take2) begin
            v2_q <= 1'b1;
          end
          idx_q <= idx_q + 1'b1;
          if (idx_q == next_q - 1'b1) begin
            state_q <= S_MERGE;
          end
        end
        S_MERGE: begin
          idx_q <= '0;
          v1_q  <= 1'b0;
          v2_q  <= 1'b0;
          // Fewer than two live nodes means the tree is complete
          if (v2_q) begin
            next_q  <= next_q + 1'b1;
            state_q <= S_SCAN;
          end else begin
            state_q <= S_FIN;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_LOAD) begin
      weight[idx_q] <= weight_t'(cnt_i);
      live[idx_q]   <= (cnt_i != '0);
      par[idx_q]    <= '0;
      branch[idx_q] <= 1'b0;
    end
    if ((state_q == S_SCAN) && take1) begin
      min1_q <= idx_q;
      w1_q   <= w_cur;
      min2_q <= min1_q;
      w2_q   <= w1_q;
    end else if ((state_q == S_SCAN) && take2) begin
      min2_q <= idx_q;
      w2_q   <= w_cur;
    end
    if (state_q == S_MERGE) begin
      if (v2_q) begin
        weight[next_q] <= w1_q + w2_q;
        live[next_q]   <= 1'b1;
        par[next_q]    <= '0;
        branch[next_q] <= 1'b0;
        live[min1_q]   <= 1'b0;
        live[min2_q]   <= 1'b0;
        par[min1_q]    <= next_q;
        branch[min1_q] <= 1'b0;
        par[min2_q]    <= next_q;
        branch[min2_q] <= 1'b1;
      end else if (v1_q && (min1_q < NODE_W'(NUM_SYM))) begin
        // Lone leaf hangs on branch 0 of a virtual root at node 16
        par[min1_q] <= next_q;
        par[next_q] <= '0;
      end
    end
  end

  assign cnt_addr_o = idx_q[SYM_W-1:0];

  // Parent 0 marks the root or an unused leaf
  assign par_o    = par[par_addr_i];
  assign branch_o = branch[par_addr_i];

  assign tree_done_o = (state_q == S_FIN);

endmodule

//--- huff_codebook.sv
`timescale 1ns/100ps
module huff_codebook (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  huff_pkg::phase_t              phase_i,
  input  logic [huff_pkg::NODE_W-1:0]   par_i,
  input  logic                          branch_i,
  input  logic [huff_pkg::SYM_W-1:0]    code_addr_i,
  output logic [huff_pkg::NODE_W-1:0]   par_addr_o,
  output logic [huff_pkg::CODE_MAX-1:0] code_o,
  output logic [huff_pkg::LEN_W-1:0]    code_len_o,
  output logic                          code_done_o
);
  import huff_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_CLIMB, S_FIN} state_t;

  state_t              state_q;
  logic [SYM_W-1:0]    leaf_q;
  logic [NODE_W-1:0]   node_q;
  logic [CODE_MAX-1:0] acc_q;
  logic [LEN_W-1:0]    len_q;

  logic [CODE_MAX-1:0] code_mem [NUM_SYM];
  logic [LEN_W-1:0]    len_mem  [NUM_SYM];

  logic at_root;

  assign par_addr_o = node_q;
  // A dead leaf looks like a root on its first step and gets length 0
  assign at_root = (par_i == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      leaf_q  <= '0;
      node_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (phase_i == CODE) begin
            state_q <= S_CLIMB;
            leaf_q  <= '0;
            node_q  <= '0;
          end
        end
        S_CLIMB: begin
          if (!at_root) begin
            node_q <= par_i;
          end else if (leaf_q == SYM_W'(NUM_SYM - 1)) begin
            state_q <= S_FIN;
          end else begin
            leaf_q <= leaf_q + 1'b1;
            node_q <= NODE_W'(leaf_q) + 1'b1;
          end
        end
        default: begin
          state_q <= S_IDLE;
        end
      endcase
    end
  end

  // Leaf side bit enters first, so the root side bit ends at bit 0
  always_ff @(posedge clk_i) begin
    if ((state_q == S_CLIMB) && at_root) begin
      code_mem[leaf_q] <= acc_q;
      len_mem[leaf_q]  <= len_q;
    end
    if ((state_q != S_CLIMB) || at_root) begin
      acc_q <= '0;
      len_q <= '0;
    end else begin
      acc_q <= {acc_q[CODE_MAX-2:0], branch_i};
      len_q <= len_q + 1'b1;
    end
  end

  assign code_o     = code_mem[code_addr_i];
  assign code_len_o = len_mem[code_addr_i];

  assign code_done_o = (state_q == S_FIN);

endmodule

//--- huff_translation.sv
`timescale 1ns/100ps
module huff_translation (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  huff_pkg::phase_t              phase_i,
  input  logic [huff_pkg::SYM_W-1:0]    sym_i,
  input  logic                          sym_valid_i,
  input  logic                          sym_last_i,
  input  logic [huff_pkg::CODE_MAX-1:0] code_i,
  input  logic [huff_pkg::LEN_W-1:0]    code_len_i,
  input  logic                          out_credit_i,
  output logic [huff_pkg::SYM_W-1:0]    code_addr_o,
  output logic                          bit_o,
  output logic                          bit_valid_o,
  output logic                          idle_o,
  output logic                          enc_done_o
);
  import huff_pkg::*;

  typedef logic [$clog2(OUT_CREDITS+1)-1:0] credit_t;

  logic                busy_q;
  logic                last_q;
  logic [LEN_W-1:0]    left_q;
  credit_t             credit_q;
  logic [CODE_MAX-1:0] shift_q;

  logic accept;
  logic send;

  // Codebook lookup happens in the cycle the symbol arrives
  assign code_addr_o = sym_i;

  assign accept = (phase_i == ENCODE) && sym_valid_i && !busy_q;
  assign send   = (phase_i == ENCODE) && busy_q && (credit_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q   <= 1'b0;
      last_q   <= 1'b0;
      left_q   <= '0;
      credit_q <= credit_t'(OUT_CREDITS);
    end else begin
      if (accept) begin
        busy_q <= (code_len_i != '0);
        left_q <= code_len_i;
        last_q <= sym_last_i;
      end else if (send) begin
        left_q <= left_q - 1'b1;
        if (left_q == LEN_W'(1)) begin
          busy_q <= 1'b0;
        end
      end
      // One credit back per pulse, one spent per bit
      case ({out_credit_i, send})
        2'b10:   credit_q <= credit_q + 1'b1;
        2'b01:   credit_q <= credit_q - 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

  // Root side bit goes out first
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_q <= code_i;
    end else if (send) begin
      shift_q <= shift_q >> 1;
    end
  end

  assign bit_o       = shift_q[0];
  assign bit_valid_o = send;
  assign idle_o      = !busy_q;
  assign enc_done_o  = send && last_q && (left_q == LEN_W'(1));

endmodule

//--- huff_top.sv
`timescale 1ns/100ps
module huff_top (
  input  logic                       hwclk_i,
  input  logic                       arst_n_i,
  input  logic                       start_i,
  input  logic [huff_pkg::SYM_W-1:0] sym_i,
  input  logic                       sym_valid_i,
  input  logic                       sym_last_i,
  input  logic                       out_credit_i,
  output logic                       sym_credit_o,
  output logic                       bit_o,
  output logic                       bit_valid_o,
  output logic                       done_o
);
  import huff_pkg::*;

  typedef logic [$clog2(IN_CREDITS+1)-1:0] owed_t;

  phase_t              phase;
  logic                histo_done;
  logic                tree_done;
  logic                code_done;
  logic                enc_done;
  logic                trn_idle;
  logic [SYM_W-1:0]    cnt_addr;
  logic [CNT_W-1:0]    cnt;
  logic [NODE_W-1:0]   par_addr;
  logic [NODE_W-1:0]   par;
  logic                branch;
  logic [SYM_W-1:0]    code_addr;
  logic [CODE_MAX-1:0] code;
  logic [LEN_W-1:0]    code_len;

  owed_t owed_q;
  logic  grant;
  logic  take;
  logic  end_pass;

  assign take     = sym_valid_i && ((phase == COUNT) || (phase == ENCODE));
  assign end_pass = take && sym_last_i;

  // Encoding takes one symbol at a time, and only once the last code is out
  always_comb begin
    case (phase)
      COUNT:   grant = (owed_q < owed_t'(IN_CREDITS)) && !end_pass;
      ENCODE:  grant = trn_idle && (owed_q == '0);
      default: grant = 1'b0;
    endcase
  end

  // Source drops any unused credit after the last symbol of a pass
  always_ff @(posedge hwclk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      owed_q <= '0;
    end else if (end_pass) begin
      owed_q <= '0;
    end else begin
      case ({grant, take})
        2'b10:   owed_q <= owed_q + 1'b1;
        2'b01:   owed_q <= owed_q - 1'b1;
        default: owed_q <= owed_q;
      endcase
    end
  end

  assign sym_credit_o = grant;

  huff_controller u_controller (
    .clk_i        (hwclk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .histo_done_i (histo_done),
    .tree_done_i  (tree_done),
    .code_done_i  (code_done),
    .enc_done_i   (enc_done),
    .phase_o      (phase),
    .done_o       (done_o)
  );

  huff_histogram u_histogram (
    .clk_i        (hwclk_i),
    .arst_n_i     (arst_n_i),
    .phase_i      (phase),
    .sym_i        (sym_i),
    .sym_valid_i  (sym_valid_i),
    .sym_last_i   (sym_last_i),
    .cnt_addr_i   (cnt_addr),
    .cnt_o        (cnt),
    .histo_done_o (histo_done)
  );

  huff_tree_builder u_tree_builder (
    .clk_i       (hwclk_i),
    .arst_n_i    (arst_n_i),
    .phase_i     (phase),
    .cnt_i       (cnt),
    .par_addr_i  (par_addr),
    .cnt_addr_o  (cnt_addr),
    .par_o       (par),
    .branch_o    (branch),
    .tree_done_o (tree_done)
  );

  huff_codebook u_codebook (
    .clk_i       (hwclk_i),
    .arst_n_i    (arst_n_i),
    .phase_i     (phase),
    .par_i       (par),
    .branch_i    (branch),
    .code_addr_i (code_addr),
    .par_addr_o  (par_addr),
    .code_o      (code),
    .code_len_o  (code_len),
    .code_done_o (code_done)
  );

  huff_translation u_translation (
    .clk_i        (hwclk_i),
    .arst_n_i     (arst_n_i),
    .phase_i      (phase),
    .sym_i        (sym_i),
    .sym_valid_i  (sym_valid_i),
    .sym_last_i   (sym_last_i),
    .code_i       (code),
    .code_len_i   (code_len),
    .out_credit_i (out_credit_i),
    .code_addr_o  (code_addr),
    .bit_o        (bit_o),
    .bit_valid_o  (bit_valid_o),
    .idle_o       (trn_idle),
    .enc_done_o   (enc_done)
  );

endmodule

//--- huff_top_sva.sv
`timescale 1ns/100ps
module huff_top_sva (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  huff_pkg::phase_t                                 phase_i,
  input  logic                                             bit_valid_i,
  input  logic                                             out_credit_i,
  input  logic [$clog2(huff_pkg::OUT_CREDITS + 1) - 1:0]   credit_i
);
  import huff_pkg::*;

  // Credits as seen from the handshake pins alone
  int held_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      held_q <= OUT_CREDITS;
    end else begin
      held_q <= held_q + int'(out_credit_i) - int'(bit_valid_i);
    end
  end

  // A bit only leaves while the sink has room for it
  bit_needs_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bit_valid_i |-> (held_q > 0))
    else $error("bit_valid_o raised with no output credit");

  // Returned credits never pile up above the reset value
  credit_bounded: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    int'(credit_i) <= OUT_CREDITS)
    else $error("output credit count above its limit");

  // Output is quiet outside ENCODE and in the cycle that enters it
  bits_only_in_encode: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ((phase_i != ENCODE) || ($past(phase_i) != ENCODE)) |-> !bit_valid_i)
    else $error("bit_valid_o raised outside ENCODE");

endmodule

bind huff_translation huff_top_sva u_sva (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .phase_i      (phase_i),
  .bit_valid_i  (bit_valid_o),
  .out_credit_i (out_credit_i),
  .credit_i     (credit_q)
);

//--- tb_huff_top.sv
`timescale 1ns/100ps
module tb_huff_top;
  import huff_pkg::*;

  localparam int NUM_ROWS = 5;
  // Each message needs well under 400 cycles even with back-pressure
  localparam int CYCLE_LIMIT = 400 * NUM_ROWS;

  // Symbols packed first in the low nibble, expected bits first at the top
  typedef struct packed {
    logic [31:0] len;
    logic [31:0] syms;
    logic [31:0] nbits;
    logic [31:0] bits;
  } row_t;

  logic             hwclk_i;
  logic             arst_n_i;
  logic             start_i;
  logic [SYM_W-1:0] sym_i;
  logic             sym_valid_i;
  logic             sym_last_i;
  logic             out_credit_i;
  logic             sym_credit_o;
  logic             bit_o;
  logic             bit_valid_o;
  logic             done_o;

  row_t        table_rows [NUM_ROWS];
  row_t        cur;
  int          row_id;
  int          cycles;
  int          main_errors;

  // Symbol source state
  int          src_row;
  int          held;
  int          idx;
  int          pass_no;
  logic        src_active;
  int          src_errors;

  // Bit sink state
  int          sink_row;
  int          owed_back;
  int          nbits;
  logic [31:0] got;
  logic [15:0] lfsr;
  logic        pick;
  logic        done_prev;
  int          sink_errors;

  huff_top u_huff_top (
    .hwclk_i      (hwclk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .sym_i        (sym_i),
    .sym_valid_i  (sym_valid_i),
    .sym_last_i   (sym_last_i),
    .out_credit_i (out_credit_i),
    .sym_credit_o (sym_credit_o),
    .bit_o        (bit_o),
    .bit_valid_o  (bit_valid_o),
    .done_o       (done_o)
  );

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  task automatic check_bit(input string name, input logic value, input logic expected);
    if (value !== expected) begin
      $display("FAILED %s: got 0x%0h expected 0x%0h", name, value, expected);
      main_errors++;
    end
  endtask

  task automatic pulse_start();
    @(posedge hwclk_i);
    start_i <= 1'b1;
    @(posedge hwclk_i);
    start_i <= 1'b0;
    // COUNT has begun, so done_o has dropped
    @(posedge hwclk_i);
    check_bit("done_o", done_o, 1'b0);
  endtask

  initial begin
    hwclk_i = 1'b0;
    forever #20 hwclk_i = ~hwclk_i;
  end

  // Symbol source: sends one symbol per held credit, message twice
  initial begin
    sym_i       <= '0;
    sym_valid_i <= 1'b0;
    sym_last_i  <= 1'b0;
    src_row    = 0;
    held       = 0;
    idx        = 0;
    pass_no    = 0;
    src_active = 1'b0;
    src_errors = 0;
    forever begin
      @(posedge hwclk_i);
      if (row_id != src_row) begin
        src_row    = row_id;
        held       = 0;
        idx        = 0;
        pass_no    = 0;
        src_active = 1'b1;
      end
      if (sym_credit_o) begin
        if (!src_active) begin
          $display("ERROR: symbol credit granted outside the two passes, cycle %0d", cycles);
          src_errors++;
        end
        held++;
      end
      if (sym_valid_i) begin
        held--;
        if (sym_last_i) begin
          // Unused credits lapse at the end of a pass
          held = 0;
          idx  = 0;
          if (pass_no == 0) begin
            pass_no = 1;
          end else begin
            src_active = 1'b0;
          end
        end
      end
      if (held > IN_CREDITS) begin
        $display("FAILED sym_credit_o outstanding: got 0x%0h expected at most 0x%0h",
                 held, IN_CREDITS);
        src_errors++;
      end
      if (src_active && (held > 0) && (idx < cur.len)) begin
        sym_i       <= cur.syms[idx*4 +: 4];
        sym_valid_i <= 1'b1;
        sym_last_i  <= (idx == cur.len - 1);
        idx++;
      end else begin
        sym_valid_i <= 1'b0;
        sym_last_i  <= 1'b0;
      end
    end
  end

  // Bit sink: collects bits and hands credits back at random
  initial begin
    out_credit_i <= 1'b0;
    sink_row    = 0;
    owed_back   = 0;
    nbits       = 0;
    got         = '0;
    lfsr        = 16'd45;
    done_prev   = 1'b0;
    sink_errors = 0;
    forever begin
      @(posedge hwclk_i);
      if (row_id != sink_row) begin
        sink_row = row_id;
        nbits    = 0;
        got      = '0;
      end
      if (out_credit_i) begin
        owed_back--;
      end
      if (bit_valid_o) begin
        got = {got[30:0], bit_o};
        nbits++;
        owed_back++;
      end
      if (owed_back > OUT_CREDITS) begin
        $display("FAILED bit_valid_o in flight: got 0x%0h expected at most 0x%0h",
                 owed_back, OUT_CREDITS);
        sink_errors++;
      end
      if (done_o && !done_prev && (nbits != cur.nbits)) begin
        $display("FAILED done_o rose after 0x%0h bits, expected 0x%0h", nbits, cur.nbits);
        sink_errors++;
      end
      done_prev = done_o;
      if (owed_back > 0) begin
        // Roughly one cycle in four returns a credit, so the stream stalls
        lfsr = next_lfsr(lfsr);
        pick = lfsr[0];
        lfsr = next_lfsr(lfsr);
        out_credit_i <= pick & lfsr[0];
      end else begin
        out_credit_i <= 1'b0;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge hwclk_i);
      cycles++;
    end
    $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("errors: source %0d, sink %0d, result %0d", src_errors, sink_errors, main_errors);
    $display("tests failed");
    $finish;
  end

  initial begin
    arst_n_i <= 1'b0;
    start_i  <= 1'b0;
    row_id      = 0;
    main_errors = 0;
    cur         = '0;
    // Skewed pair, lone symbol, balanced four, deeper tree, extreme symbols
    table_rows[0] = '{32'd4, 32'h0000_1000, 32'd4,  32'b1110};
    table_rows[1] = '{32'd3, 32'h0000_0555, 32'd3,  32'b000};
    table_rows[2] = '{32'd4, 32'h0000_5432, 32'd8,  32'b0001_1011};
    table_rows[3] = '{32'd8, 32'h4121_3121, 32'd14, 32'b01_0011_0010_0111};
    table_rows[4] = '{32'd6, 32'h00EF_0F0F, 32'd9,  32'b0_1101_1010};
    repeat (3) @(posedge hwclk_i);
    arst_n_i <= 1'b1;
    @(posedge hwclk_i);
    check_bit("sym_credit_o", sym_credit_o, 1'b0);
    check_bit("bit_valid_o", bit_valid_o, 1'b0);
    check_bit("done_o", done_o, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      cur    = table_rows[r];
      row_id = r + 1;
      pulse_start();
      while (done_o !== 1'b1) begin
        @(posedge hwclk_i);
      end
      if (nbits != cur.nbits) begin
        $display("FAILED bit_valid_o count row %0d: got 0x%0h expected 0x%0h",
                 r, nbits, cur.nbits);
        main_errors++;
      end
      if (got != cur.bits) begin
        $display("FAILED bit_o stream row %0d: got 0x%0h expected 0x%0h", r, got, cur.bits);
        main_errors++;
      end
      if (src_active) begin
        $display("ERROR: row %0d finished before the engine took both passes", r);
        main_errors++;
      end
      // done_o holds until the next start
      repeat (3) begin
        @(posedge hwclk_i);
        check_bit("done_o", done_o, 1'b1);
      end
    end
    $display("errors: source %0d, sink %0d, result %0d", src_errors, sink_errors, main_errors);
    if ((src_errors + sink_errors + main_errors) == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- huff_top.f
huff_pkg.sv
huff_controller.sv
huff_histogram.sv
huff_tree_builder.sv
huff_codebook.sv
huff_translation.sv
huff_top.sv
huff_top_sva.sv
tb_huff_top.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_huff_top
FILELIST := huff_top.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
